// File: cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    typedef logic [31:0] word_t;    // data, address and instruction word
    typedef logic [4:0]  regaddr_t; // register index

    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,
        ALU_AND   = 4'd2,
        ALU_OR    = 4'd3,
        ALU_XOR   = 4'd4,
        ALU_SLL   = 4'd5,
        ALU_SRL   = 4'd6,
        ALU_SRA   = 4'd7,
        ALU_SLT   = 4'd8,
        ALU_SLTU  = 4'd9,
        ALU_PASS2 = 4'd10           // operand 2 straight through, for lui
    } alu_mode_t;

    typedef enum logic [1:0] {
        MA_X     = 2'd0,            // no memory access
        MA_LOAD  = 2'd1,
        MA_STORE = 2'd2
    } ma_mode_t;

    // same codes as the funct3 field of loads and stores
    typedef enum logic [2:0] {
        MA_B  = 3'd0,
        MA_H  = 3'd1,
        MA_W  = 3'd2,
        MA_BU = 3'd4,
        MA_HU = 3'd5
    } ma_size_t;

    typedef enum logic [1:0] {
        WB_SRC_ALU  = 2'd0,
        WB_SRC_MEM  = 2'd1,
        WB_SRC_DATA = 2'd2          // value computed upstream
    } wb_src_t;

    localparam word_t    NOP_PC       = 32'hffff_ffff; // bubble marker
    localparam word_t    NOP_IR       = 32'h0000_0013; // addi x0,x0,0
    localparam ma_mode_t NOP_MA_MODE  = MA_X;
    localparam ma_size_t NOP_MA_SIZE  = MA_W;
    localparam wb_src_t  NOP_WB_SRC   = WB_SRC_DATA;
    localparam logic     NOP_WB_VALID = 1'b0;

endpackage

`default_nettype wire

// File: alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu (
    input  wire cpu_pkg::alu_mode_t alu_mode_i,        // operation select
    input  wire cpu_pkg::word_t     alu_op1_i,         // rs1 side
    input  wire cpu_pkg::word_t     alu_op2_i,         // rs2 or immediate
    output cpu_pkg::word_t          alu_result_async_o // result
);

    logic [4:0]     shamt;       // shift amount
    logic           lt_signed;
    logic           lt_unsigned;
    cpu_pkg::word_t sra_result;

    always_comb begin
        shamt       = alu_op2_i[4:0];
        lt_signed   = $signed(alu_op1_i) < $signed(alu_op2_i);
        lt_unsigned = alu_op1_i < alu_op2_i;
        sra_result  = $signed(alu_op1_i) >>> shamt; // sign bit fills from the left
    end

    always_comb begin
        case (alu_mode_i)
            cpu_pkg::ALU_ADD: begin
                alu_result_async_o = alu_op1_i + alu_op2_i;
            end
            cpu_pkg::ALU_SUB: begin
                alu_result_async_o = alu_op1_i - alu_op2_i;
            end
            cpu_pkg::ALU_AND:   alu_result_async_o = alu_op1_i & alu_op2_i;
            cpu_pkg::ALU_OR:    alu_result_async_o = alu_op1_i | alu_op2_i;
            cpu_pkg::ALU_XOR:   alu_result_async_o = alu_op1_i ^ alu_op2_i;
            cpu_pkg::ALU_SLL:   alu_result_async_o = alu_op1_i << shamt;
            cpu_pkg::ALU_SRL:   alu_result_async_o = alu_op1_i >> shamt;
            cpu_pkg::ALU_SRA:   alu_result_async_o = sra_result;
            cpu_pkg::ALU_SLT:   alu_result_async_o = {31'b0, lt_signed};
            cpu_pkg::ALU_SLTU:  alu_result_async_o = {31'b0, lt_unsigned};
            cpu_pkg::ALU_PASS2: alu_result_async_o = alu_op2_i; // lui
            default:            alu_result_async_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: cpu_ex.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_ex (
    input  wire                     clk_i,
    input  wire                     rst_i,

    input  wire cpu_pkg::word_t     pc_i,             // program counter
    input  wire cpu_pkg::word_t     ir_i,             // instruction word
    input  wire cpu_pkg::word_t     alu_op1_i,
    input  wire cpu_pkg::word_t     alu_op2_i,
    input  wire cpu_pkg::alu_mode_t alu_mode_i,
    input  wire cpu_pkg::ma_mode_t  ma_mode_i,        // load, store or none
    input  wire cpu_pkg::ma_size_t  ma_size_i,
    input  wire cpu_pkg::word_t     ma_data_i,        // store data
    input  wire cpu_pkg::wb_src_t   wb_src_i,
    input  wire cpu_pkg::word_t     wb_data_i,
    input  wire                     wb_valid_i,       // register write requested

    output cpu_pkg::regaddr_t       wb_addr_async_o,  // forwarded rd
    output cpu_pkg::word_t          wb_data_async_o,
    output logic                    wb_ready_async_o, // forwarded data usable now
    output logic                    wb_valid_async_o,
    output logic                    empty_async_o,    // bubble in this stage

    output cpu_pkg::word_t          pc_o,
    output cpu_pkg::word_t          ir_o,
    output cpu_pkg::word_t          ma_addr_o,
    output cpu_pkg::ma_mode_t       ma_mode_o,
    output cpu_pkg::ma_size_t       ma_size_o,
    output cpu_pkg::word_t          ma_data_o,
    output cpu_pkg::wb_src_t        wb_src_o,
    output cpu_pkg::word_t          wb_data_o,
    output logic                    wb_valid_o
);

    cpu_pkg::word_t alu_result;

    alu u_alu (
        .alu_mode_i         (alu_mode_i),
        .alu_op1_i          (alu_op1_i),
        .alu_op2_i          (alu_op2_i),
        .alu_result_async_o (alu_result)
    );

    always_comb begin
        wb_addr_async_o  = ir_i[11:7];
        wb_data_async_o  = (wb_src_i == cpu_pkg::WB_SRC_ALU) ? alu_result : wb_data_i;
        wb_ready_async_o = (wb_src_i != cpu_pkg::WB_SRC_MEM); // load data comes later
        wb_valid_async_o = wb_valid_i;
        empty_async_o    = (pc_i == cpu_pkg::NOP_PC);
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pc_o       <= cpu_pkg::NOP_PC;
            ir_o       <= cpu_pkg::NOP_IR;
            ma_mode_o  <= cpu_pkg::NOP_MA_MODE;
            ma_size_o  <= cpu_pkg::NOP_MA_SIZE;
            wb_src_o   <= cpu_pkg::NOP_WB_SRC;
            wb_valid_o <= cpu_pkg::NOP_WB_VALID;
        end else begin
            pc_o       <= pc_i;
            ir_o       <= ir_i;
            ma_mode_o  <= ma_mode_i;
            ma_size_o  <= ma_size_i;
            wb_src_o   <= wb_src_i;
            wb_valid_o <= wb_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        ma_addr_o <= (ma_mode_i == cpu_pkg::MA_X) ? '0 : alu_result; // effective address
        ma_data_o <= ma_data_i;
        wb_data_o <= wb_data_async_o;
    end

    // the decoder only hands over modes the alu knows
    a_alu_mode_known: assert property (@(posedge clk_i) disable iff (rst_i)
        !$isunknown(alu_mode_i) && (alu_mode_i <= cpu_pkg::ALU_PASS2));

    // a bubble must reach memory access without a register write
    a_bubble_no_write: assert property (@(posedge clk_i) disable iff (rst_i)
        (pc_i == cpu_pkg::NOP_PC) |=> !wb_valid_o);

endmodule

`default_nettype wire

// File: cpu_ma.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_ma #(
    parameter int MEM_WORDS = 256                     // data memory depth in words
) (
    input  wire                     clk_i,
    input  wire                     rst_i,

    input  wire cpu_pkg::word_t     pc_i,
    input  wire cpu_pkg::word_t     ir_i,
    input  wire cpu_pkg::word_t     ma_addr_i,
    input  wire cpu_pkg::ma_mode_t  ma_mode_i,
    input  wire cpu_pkg::ma_size_t  ma_size_i,
    input  wire cpu_pkg::word_t     ma_data_i,
    input  wire cpu_pkg::wb_src_t   wb_src_i,
    input  wire cpu_pkg::word_t     wb_data_i,
    input  wire                     wb_valid_i,

    output cpu_pkg::regaddr_t       wb_addr_async_o,
    output cpu_pkg::word_t          wb_data_async_o,
    output logic                    wb_ready_async_o, // low while a load is here
    output logic                    wb_valid_async_o,

    output cpu_pkg::word_t          pc_o,
    output cpu_pkg::regaddr_t       wb_addr_o,
    output cpu_pkg::word_t          wb_data_o,        // final write-back value
    output logic                    wb_valid_o
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    cpu_pkg::word_t    mem [MEM_WORDS] = '{default: '0}; // data memory, starts cleared
    logic [IDX_W-1:0]  mem_idx;        // word index, wraps at the depth
    logic [3:0]        st_be;          // store byte lanes
    cpu_pkg::word_t    st_data;        // store data copied to every lane
    cpu_pkg::word_t    rd_data;        // raw word of the last load
    cpu_pkg::ma_mode_t ma_mode_r;
    cpu_pkg::wb_src_t  wb_src_r;
    cpu_pkg::ma_size_t ld_size_r;
    logic [1:0]        ld_lane_r;      // low address bits of the load
    cpu_pkg::word_t    wb_data_r;
    logic [7:0]        ld_byte;
    logic [15:0]       ld_half;
    cpu_pkg::word_t    ld_value;       // extended load result

    always_comb begin
        wb_addr_async_o  = ir_i[11:7];
        wb_data_async_o  = wb_data_i;
        wb_ready_async_o = (ma_mode_i != cpu_pkg::MA_LOAD);
        wb_valid_async_o = wb_valid_i;
    end

    always_comb begin
        mem_idx = ma_addr_i[IDX_W+1:2];
        case (ma_size_i)
            cpu_pkg::MA_B, cpu_pkg::MA_BU: begin
                st_be   = 4'b0001 << ma_addr_i[1:0];
                st_data = {4{ma_data_i[7:0]}};
            end
            cpu_pkg::MA_H, cpu_pkg::MA_HU: begin
                st_be   = ma_addr_i[1] ? 4'b1100 : 4'b0011; // bit 0 ignored, aligned down
                st_data = {2{ma_data_i[15:0]}};
            end
            default: begin
                st_be   = 4'b1111;
                st_data = ma_data_i;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i && ma_mode_i == cpu_pkg::MA_STORE) begin
            for (int b = 0; b < 4; b++) begin
                if (st_be[b]) begin
                    mem[mem_idx][b*8 +: 8] <= st_data[b*8 +: 8];
                end
            end
        end
        if (ma_mode_i == cpu_pkg::MA_LOAD) begin
            rd_data <= mem[mem_idx];
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pc_o       <= cpu_pkg::NOP_PC;
            wb_valid_o <= cpu_pkg::NOP_WB_VALID;
            ma_mode_r  <= cpu_pkg::NOP_MA_MODE;
            wb_src_r   <= cpu_pkg::NOP_WB_SRC;
        end else begin
            pc_o       <= pc_i;
            wb_valid_o <= wb_valid_i;
            ma_mode_r  <= ma_mode_i;
            wb_src_r   <= wb_src_i;
        end
    end

    always_ff @(posedge clk_i) begin
        wb_addr_o <= ir_i[11:7];
        wb_data_r <= wb_data_i;
        ld_size_r <= ma_size_i;
        ld_lane_r <= ma_addr_i[1:0];
    end

    always_comb begin
        ld_byte = rd_data[{ld_lane_r, 3'b000} +: 8];
        ld_half = ld_lane_r[1] ? rd_data[31:16] : rd_data[15:0];
        case (ld_size_r)
            cpu_pkg::MA_B:  ld_value = {{24{ld_byte[7]}}, ld_byte};
            cpu_pkg::MA_H:  ld_value = {{16{ld_half[15]}}, ld_half};
            cpu_pkg::MA_BU: ld_value = {24'b0, ld_byte};
            cpu_pkg::MA_HU: ld_value = {16'b0, ld_half};
            default:        ld_value = rd_data;
        endcase
        if (wb_src_r == cpu_pkg::WB_SRC_MEM && ma_mode_r == cpu_pkg::MA_LOAD) begin
            wb_data_o = ld_value;
        end else begin
            wb_data_o = wb_data_r;
        end
    end

    // upstream decode must route every load result through memory
    a_load_src_mem: assert property (@(posedge clk_i) disable iff (rst_i)
        (ma_mode_i == cpu_pkg::MA_LOAD) |-> (wb_src_i == cpu_pkg::WB_SRC_MEM));

endmodule

`default_nettype wire

// File: ex_ma_top.sv
`timescale 1ns/10ps
`default_nettype none

module ex_ma_top #(
    parameter int MEM_WORDS = 256             // data memory depth in words
) (
    input  wire                     clk_i,
    input  wire                     rst_i,

    input  wire cpu_pkg::word_t     pc_i,
    input  wire cpu_pkg::word_t     ir_i,
    input  wire cpu_pkg::word_t     alu_op1_i,
    input  wire cpu_pkg::word_t     alu_op2_i,
    input  wire cpu_pkg::alu_mode_t alu_mode_i,
    input  wire cpu_pkg::ma_mode_t  ma_mode_i,
    input  wire cpu_pkg::ma_size_t  ma_size_i,
    input  wire cpu_pkg::word_t     ma_data_i,
    input  wire cpu_pkg::wb_src_t   wb_src_i,
    input  wire cpu_pkg::word_t     wb_data_i,
    input  wire                     wb_valid_i,

    output cpu_pkg::regaddr_t       ex_fwd_addr_o,  // execute stage forwarding
    output cpu_pkg::word_t          ex_fwd_data_o,
    output logic                    ex_fwd_ready_o,
    output logic                    ex_fwd_valid_o,
    output logic                    ex_empty_o,

    output cpu_pkg::regaddr_t       ma_fwd_addr_o,  // memory stage forwarding
    output cpu_pkg::word_t          ma_fwd_data_o,
    output logic                    ma_fwd_ready_o,
    output logic                    ma_fwd_valid_o,

    output cpu_pkg::word_t          pc_o,           // write-back slot
    output cpu_pkg::regaddr_t       wb_addr_o,
    output cpu_pkg::word_t          wb_data_o,
    output logic                    wb_valid_o
);

    cpu_pkg::word_t    ex_pc;
    cpu_pkg::word_t    ex_ir;
    cpu_pkg::word_t    ex_ma_addr;
    cpu_pkg::ma_mode_t ex_ma_mode;
    cpu_pkg::ma_size_t ex_ma_size;
    cpu_pkg::word_t    ex_ma_data;
    cpu_pkg::wb_src_t  ex_wb_src;
    cpu_pkg::word_t    ex_wb_data;
    logic              ex_wb_valid;

    cpu_ex u_cpu_ex (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .pc_i             (pc_i),
        .ir_i             (ir_i),
        .alu_op1_i        (alu_op1_i),
        .alu_op2_i        (alu_op2_i),
        .alu_mode_i       (alu_mode_i),
        .ma_mode_i        (ma_mode_i),
        .ma_size_i        (ma_size_i),
        .ma_data_i        (ma_data_i),
        .wb_src_i         (wb_src_i),
        .wb_data_i        (wb_data_i),
        .wb_valid_i       (wb_valid_i),
        .wb_addr_async_o  (ex_fwd_addr_o),
        .wb_data_async_o  (ex_fwd_data_o),
        .wb_ready_async_o (ex_fwd_ready_o),
        .wb_valid_async_o (ex_fwd_valid_o),
        .empty_async_o    (ex_empty_o),
        .pc_o             (ex_pc),
        .ir_o             (ex_ir),
        .ma_addr_o        (ex_ma_addr),
        .ma_mode_o        (ex_ma_mode),
        .ma_size_o        (ex_ma_size),
        .ma_data_o        (ex_ma_data),
        .wb_src_o         (ex_wb_src),
        .wb_data_o        (ex_wb_data),
        .wb_valid_o       (ex_wb_valid)
    );

    cpu_ma #(
        .MEM_WORDS (MEM_WORDS)
    ) u_cpu_ma (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .pc_i             (ex_pc),
        .ir_i             (ex_ir),
        .ma_addr_i        (ex_ma_addr),
        .ma_mode_i        (ex_ma_mode),
        .ma_size_i        (ex_ma_size),
        .ma_data_i        (ex_ma_data),
        .wb_src_i         (ex_wb_src),
        .wb_data_i        (ex_wb_data),
        .wb_valid_i       (ex_wb_valid),
        .wb_addr_async_o  (ma_fwd_addr_o),
        .wb_data_async_o  (ma_fwd_data_o),
        .wb_ready_async_o (ma_fwd_ready_o),
        .wb_valid_async_o (ma_fwd_valid_o),
        .pc_o             (pc_o),
        .wb_addr_o        (wb_addr_o),
        .wb_data_o        (wb_data_o),
        .wb_valid_o       (wb_valid_o)
    );

endmodule

`default_nettype wire

// File: ex_ma_checker.sv
`timescale 1ns/10ps
`default_nettype none

module ex_ma_checker #(
    parameter int MEM_WORDS = 256
) (
    input  wire                     clk_i,
    input  wire                     rst_i,
    input  wire [2:0]               test_i,          // test of the driven slot
    input  wire                     finish_i,
    input  wire cpu_pkg::word_t     pc_i,
    input  wire cpu_pkg::word_t     ir_i,
    input  wire cpu_pkg::word_t     alu_op1_i,
    input  wire cpu_pkg::word_t     alu_op2_i,
    input  wire cpu_pkg::alu_mode_t alu_mode_i,
    input  wire cpu_pkg::ma_mode_t  ma_mode_i,
    input  wire cpu_pkg::ma_size_t  ma_size_i,
    input  wire cpu_pkg::word_t     ma_data_i,
    input  wire cpu_pkg::wb_src_t   wb_src_i,
    input  wire cpu_pkg::word_t     wb_data_i,
    input  wire                     wb_valid_i,
    input  wire cpu_pkg::regaddr_t  ex_fwd_addr_i,
    input  wire cpu_pkg::word_t     ex_fwd_data_i,
    input  wire                     ex_fwd_ready_i,
    input  wire                     ex_fwd_valid_i,
    input  wire                     ex_empty_i,
    input  wire cpu_pkg::regaddr_t  ma_fwd_addr_i,
    input  wire cpu_pkg::word_t     ma_fwd_data_i,
    input  wire                     ma_fwd_ready_i,
    input  wire                     ma_fwd_valid_i,
    input  wire cpu_pkg::word_t     out_pc_i,
    input  wire cpu_pkg::regaddr_t  out_wb_addr_i,
    input  wire cpu_pkg::word_t     out_wb_data_i,
    input  wire                     out_wb_valid_i,
    output int                      error_count_o,
    output logic                    report_done_o
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    cpu_pkg::word_t model_mem [MEM_WORDS] = '{default: '0};
    cpu_pkg::word_t q_pc[$];
    cpu_pkg::word_t q_data[$];          // final write-back value
    cpu_pkg::word_t q_fwd[$];           // value forwarded out of execute
    logic [4:0]     q_rd[$];
    logic           q_valid[$];
    logic           q_load[$];
    logic [2:0]     q_test[$];
    logic [2:0]     cur_test = 3'd0;
    int             test_checks = 0;
    int             test_errors = 0;
    int             total_checks = 0;
    int             total_errors = 0;
    cpu_pkg::word_t exp_alu;
    cpu_pkg::word_t exp_fwd;
    cpu_pkg::word_t exp_wb;
    logic [IDX_W-1:0] idx;

    function automatic cpu_pkg::word_t alu_model(input cpu_pkg::alu_mode_t mode,
                                                 input cpu_pkg::word_t a, input cpu_pkg::word_t b);
        case (mode)
            cpu_pkg::ALU_ADD:   return a + b;
            cpu_pkg::ALU_SUB:   return a - b;
            cpu_pkg::ALU_AND:   return a & b;
            cpu_pkg::ALU_OR:    return a | b;
            cpu_pkg::ALU_XOR:   return a ^ b;
            cpu_pkg::ALU_SLL:   return a << b[4:0];
            cpu_pkg::ALU_SRL:   return a >> b[4:0];
            cpu_pkg::ALU_SRA:   return $signed(a) >>> b[4:0];
            cpu_pkg::ALU_SLT:   return {31'b0, $signed(a) < $signed(b)};
            cpu_pkg::ALU_SLTU:  return {31'b0, a < b};
            cpu_pkg::ALU_PASS2: return b;
            default:            return '0;
        endcase
    endfunction

    function automatic cpu_pkg::word_t load_model(input cpu_pkg::ma_size_t size,
                                                  input cpu_pkg::word_t w, input logic [1:0] low);
        logic [7:0]  b;
        logic [15:0] h;
        b = w[{low, 3'b000} +: 8];
        h = low[1] ? w[31:16] : w[15:0];                 // half aligned down
        case (size)
            cpu_pkg::MA_B:  return {{24{b[7]}}, b};
            cpu_pkg::MA_H:  return {{16{h[15]}}, h};
            cpu_pkg::MA_BU: return {24'b0, b};
            cpu_pkg::MA_HU: return {16'b0, h};
            default:        return w;
        endcase
    endfunction

    function automatic string test_name(input logic [2:0] id);
        case (id)
            3'd0:    return "reset";
            3'd1:    return "alu operations";
            3'd2:    return "execute forwarding";
            3'd3:    return "stores then loads";
            3'd4:    return "load forwarding";
            default: return "bubbles and silent stores";
        endcase
    endfunction

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        test_checks++;
        if (act !== exp) begin
            test_errors++;
            $display("error at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic report_test();
        $display("test %0d (%s) finished: %0d checks, %0d errors",
                 cur_test, test_name(cur_test), test_checks, test_errors);
        total_checks += test_checks;
        total_errors += test_errors;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic push_slot(input cpu_pkg::word_t pc, input cpu_pkg::word_t data,
                             input cpu_pkg::word_t fwd, input logic [4:0] rd,
                             input logic valid, input logic load);
        q_pc.push_back(pc);
        q_data.push_back(data);
        q_fwd.push_back(fwd);
        q_rd.push_back(rd);
        q_valid.push_back(valid);
        q_load.push_back(load);
        q_test.push_back(test_i);
    endtask

    always @(posedge clk_i) begin
        // slot 0 sits in the write-back registers, slot 1 at the input of cpu_ma
        if (q_pc.size() == 2) begin
            if (q_test[0] != cur_test) begin
                report_test();
                cur_test = q_test[0];
            end
            compare("pc_o", q_pc[0], out_pc_i);
            compare("wb_valid_o", 32'(q_valid[0]), 32'(out_wb_valid_i));
            if (q_pc[0] != cpu_pkg::NOP_PC) begin
                compare("wb_addr_o", 32'(q_rd[0]), 32'(out_wb_addr_i));
                compare("wb_data_o", q_data[0], out_wb_data_i);
            end
            compare("ma_fwd_ready_o", 32'(!q_load[1]), 32'(ma_fwd_ready_i));
            compare("ma_fwd_valid_o", 32'(q_valid[1]), 32'(ma_fwd_valid_i));
            if (q_pc[1] != cpu_pkg::NOP_PC) begin
                compare("ma_fwd_addr_o", 32'(q_rd[1]), 32'(ma_fwd_addr_i));
                compare("ma_fwd_data_o", q_fwd[1], ma_fwd_data_i);
            end
            void'(q_pc.pop_front());
            void'(q_data.pop_front());
            void'(q_fwd.pop_front());
            void'(q_rd.pop_front());
            void'(q_valid.pop_front());
            void'(q_load.pop_front());
            void'(q_test.pop_front());
        end

        exp_alu = alu_model(alu_mode_i, alu_op1_i, alu_op2_i);
        exp_fwd = (wb_src_i == cpu_pkg::WB_SRC_ALU) ? exp_alu : wb_data_i;
        compare("ex_fwd_addr_o", 32'(ir_i[11:7]), 32'(ex_fwd_addr_i));
        compare("ex_fwd_data_o", exp_fwd, ex_fwd_data_i);
        compare("ex_fwd_ready_o", 32'(wb_src_i != cpu_pkg::WB_SRC_MEM), 32'(ex_fwd_ready_i));
        compare("ex_fwd_valid_o", 32'(wb_valid_i), 32'(ex_fwd_valid_i));
        compare("ex_empty_o", 32'(pc_i == cpu_pkg::NOP_PC), 32'(ex_empty_i));

        // memory effects in slot order match the order cpu_ma applies them
        exp_wb = exp_fwd;
        idx    = exp_alu[IDX_W+1:2];
        if (!rst_i && ma_mode_i == cpu_pkg::MA_STORE) begin
            case (ma_size_i)
                cpu_pkg::MA_B, cpu_pkg::MA_BU: begin
                    model_mem[idx][{exp_alu[1:0], 3'b000} +: 8] = ma_data_i[7:0];
                end
                cpu_pkg::MA_H, cpu_pkg::MA_HU: begin
                    model_mem[idx][{exp_alu[1], 4'b0000} +: 16] = ma_data_i[15:0];
                end
                default: model_mem[idx] = ma_data_i;
            endcase
        end else if (!rst_i && ma_mode_i == cpu_pkg::MA_LOAD) begin
            exp_wb = load_model(ma_size_i, model_mem[idx], exp_alu[1:0]);
        end

        if (rst_i) begin
            push_slot(cpu_pkg::NOP_PC, '0, '0, '0, 1'b0, 1'b0);     // reset loads a bubble
        end else begin
            push_slot(pc_i, exp_wb, exp_fwd, ir_i[11:7], wb_valid_i,
                      ma_mode_i == cpu_pkg::MA_LOAD);
        end

        if (rst_i) begin
            error_count_o <= 0;
            report_done_o <= 1'b0;
        end else if (finish_i && !report_done_o) begin
            report_test();
            $display("total: %0d checks, %0d errors", total_checks, total_errors);
            error_count_o <= total_errors;
            report_done_o <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: ex_ma_tb.sv
`timescale 1ns/10ps
`default_nettype none

module ex_ma_tb;

    localparam int MEM_WORDS   = 256;
    localparam int SEED        = 32'h9bd6a6a5;
    localparam int ALU_SLOTS   = 80;
    localparam int FWD_SLOTS   = 60;
    localparam int ST_ROUNDS   = 15;                 // one store and five loads each
    localparam int MIX_SLOTS   = 80;
    localparam int BUB_ROUNDS  = 10;                 // four slots each
    localparam int TOTAL_SLOTS = 3 + ALU_SLOTS + FWD_SLOTS + ST_ROUNDS * 6 + MIX_SLOTS
                                 + BUB_ROUNDS * 4 + 3;
    localparam int MAX_CYCLES  = TOTAL_SLOTS + 20;

    logic                 clk_i = 1'b0;
    logic                 rst_i;
    cpu_pkg::word_t       pc_i;
    cpu_pkg::word_t       ir_i;
    cpu_pkg::word_t       alu_op1_i;
    cpu_pkg::word_t       alu_op2_i;
    cpu_pkg::alu_mode_t   alu_mode_i;
    cpu_pkg::ma_mode_t    ma_mode_i;
    cpu_pkg::ma_size_t    ma_size_i;
    cpu_pkg::word_t       ma_data_i;
    cpu_pkg::wb_src_t     wb_src_i;
    cpu_pkg::word_t       wb_data_i;
    logic                 wb_valid_i;
    cpu_pkg::regaddr_t    ex_fwd_addr_o;
    cpu_pkg::word_t       ex_fwd_data_o;
    logic                 ex_fwd_ready_o;
    logic                 ex_fwd_valid_o;
    logic                 ex_empty_o;
    cpu_pkg::regaddr_t    ma_fwd_addr_o;
    cpu_pkg::word_t       ma_fwd_data_o;
    logic                 ma_fwd_ready_o;
    logic                 ma_fwd_valid_o;
    cpu_pkg::word_t       pc_o;
    cpu_pkg::regaddr_t    wb_addr_o;
    cpu_pkg::word_t       wb_data_o;
    logic                 wb_valid_o;

    logic [2:0]           test_id;                   // tags each slot for the checker
    logic                 finish;
    int                   error_count;
    logic                 report_done;
    int                   cycles = 0;
    cpu_pkg::word_t       addr;
    int                   kind;

    always #5 clk_i = ~clk_i;

    ex_ma_top #(
        .MEM_WORDS (MEM_WORDS)
    ) u_ex_ma_top (.*);

    ex_ma_checker #(
        .MEM_WORDS (MEM_WORDS)
    ) u_checker (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .test_i         (test_id),
        .finish_i       (finish),
        .pc_i           (pc_i),
        .ir_i           (ir_i),
        .alu_op1_i      (alu_op1_i),
        .alu_op2_i      (alu_op2_i),
        .alu_mode_i     (alu_mode_i),
        .ma_mode_i      (ma_mode_i),
        .ma_size_i      (ma_size_i),
        .ma_data_i      (ma_data_i),
        .wb_src_i       (wb_src_i),
        .wb_data_i      (wb_data_i),
        .wb_valid_i     (wb_valid_i),
        .ex_fwd_addr_i  (ex_fwd_addr_o),
        .ex_fwd_data_i  (ex_fwd_data_o),
        .ex_fwd_ready_i (ex_fwd_ready_o),
        .ex_fwd_valid_i (ex_fwd_valid_o),
        .ex_empty_i     (ex_empty_o),
        .ma_fwd_addr_i  (ma_fwd_addr_o),
        .ma_fwd_data_i  (ma_fwd_data_o),
        .ma_fwd_ready_i (ma_fwd_ready_o),
        .ma_fwd_valid_i (ma_fwd_valid_o),
        .out_pc_i       (pc_o),
        .out_wb_addr_i  (wb_addr_o),
        .out_wb_data_i  (wb_data_o),
        .out_wb_valid_i (wb_valid_o),
        .error_count_o  (error_count),
        .report_done_o  (report_done)
    );

    function automatic cpu_pkg::ma_size_t size_code(input int k);
        case (k)
            0:       return cpu_pkg::MA_B;
            1:       return cpu_pkg::MA_H;
            3:       return cpu_pkg::MA_BU;
            4:       return cpu_pkg::MA_HU;
            default: return cpu_pkg::MA_W;
        endcase
    endfunction

    function automatic cpu_pkg::word_t random_addr();
        return $urandom_range(MEM_WORDS * 4 - 1, 0);  // anywhere in data memory
    endfunction

    task automatic set_bubble();
        pc_i       = cpu_pkg::NOP_PC;
        ir_i       = cpu_pkg::NOP_IR;
        alu_op1_i  = '0;
        alu_op2_i  = '0;
        alu_mode_i = cpu_pkg::ALU_ADD;
        ma_mode_i  = cpu_pkg::NOP_MA_MODE;
        ma_size_i  = cpu_pkg::NOP_MA_SIZE;
        ma_data_i  = '0;
        wb_src_i   = cpu_pkg::NOP_WB_SRC;
        wb_data_i  = '0;
        wb_valid_i = cpu_pkg::NOP_WB_VALID;
    endtask

    task automatic set_random_slot(input cpu_pkg::wb_src_t src);
        pc_i       = $urandom & 32'hffff_fffc;       // aligned, never the bubble marker
        ir_i       = $urandom;
        alu_op1_i  = $urandom;
        alu_op2_i  = $urandom;
        alu_mode_i = cpu_pkg::alu_mode_t'(4'($urandom_range(10, 0)));
        ma_mode_i  = cpu_pkg::MA_X;
        ma_size_i  = cpu_pkg::MA_W;
        ma_data_i  = $urandom;
        wb_src_i   = src;
        wb_data_i  = $urandom;
        wb_valid_i = 1'($urandom_range(1, 0));
    endtask

    task automatic set_mem_slot(input cpu_pkg::ma_mode_t mode, input cpu_pkg::wb_src_t src,
                                input cpu_pkg::ma_size_t size, input cpu_pkg::word_t a);
        set_random_slot(src);
        alu_op2_i  = $urandom_range(15, 0);          // base plus small offset
        alu_op1_i  = a - alu_op2_i;
        alu_mode_i = cpu_pkg::ALU_ADD;
        ma_mode_i  = mode;
        ma_size_i  = size;
        wb_valid_i = (mode == cpu_pkg::MA_LOAD);     // stores write no register
    endtask

    // kinds: 0 alu, 1 data, 2 store, 3 load, other bubble
    task automatic drive_slot(input int k, input cpu_pkg::word_t a, input int size);
        case (k)
            0: set_random_slot(cpu_pkg::WB_SRC_ALU);
            1: set_random_slot(cpu_pkg::WB_SRC_DATA);
            2: set_mem_slot(cpu_pkg::MA_STORE, cpu_pkg::WB_SRC_DATA, size_code(size % 3), a);
            3: set_mem_slot(cpu_pkg::MA_LOAD, cpu_pkg::WB_SRC_MEM, size_code(size), a);
            default: set_bubble();
        endcase
        @(negedge clk_i);
    endtask

    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        void'($urandom(SEED));
        rst_i   = 1'b1;
        finish  = 1'b0;
        test_id = 3'd0;
        set_bubble();
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;

        test_id = 3'd1;
        repeat (ALU_SLOTS) drive_slot(0, '0, 0);

        test_id = 3'd2;
        repeat (FWD_SLOTS) begin
            kind = $urandom_range(3, 0);
            drive_slot((kind == 2) ? 4 : kind, random_addr(), $urandom_range(4, 0));
        end

        test_id = 3'd3;
        for (int r = 0; r < ST_ROUNDS; r++) begin
            addr = random_addr();
            drive_slot(2, addr, r % 3);
            for (int k = 0; k < 5; k++) begin
                drive_slot(3, {addr[31:2], 2'($urandom_range(3, 0))}, k);
            end
        end

        test_id = 3'd4;
        repeat (MIX_SLOTS) begin
            drive_slot($urandom_range(3, 0), 32'($urandom_range(31, 0)), $urandom_range(4, 0));
        end

        test_id = 3'd5;
        repeat (BUB_ROUNDS) begin
            addr = random_addr();
            drive_slot(4, '0, 0);
            drive_slot(2, addr, 2);                  // silent store, wb_valid low
            drive_slot(4, '0, 0);
            drive_slot(3, addr, 2);
        end
        repeat (3) drive_slot(4, '0, 0);             // drain both stages

        finish = 1'b1;
        wait (report_done);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: ex_ma.f
cpu_pkg.sv
alu.sv
cpu_ex.sv
cpu_ma.sv
ex_ma_top.sv
ex_ma_checker.sv
ex_ma_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= ex_ma_tb
FILELIST  ?= ex_ma.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Done: no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$($(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
